/* project.f */
+incdir+tb
source/ucodePkg.sv
source/opcodeLatch.sv
source/flowLookup.sv
source/microcodeRom.sv
source/microSequencer.sv
source/uopDecoder.sv
source/ucodeSequencer.sv
tb/tbUcodeSequencer.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tbUcodeSequencer \
	-f project.f -o simUcodeSequencer
./obj_dir/simUcodeSequencer

/* tb/tbChecks.svh */
//////////////////////////////
// Expected micro-op list
//////////////////////////////

typedef struct packed {
	uopCmd_t cmd;
	logic    inc;
	logic    fu;
	logic    last;
} expUop_t;

expUop_t expQ[$];
logic    flowClosed;

// Strobes follow the pcCtl naming and the end depends on zeroFlag
task automatic pushStep
(
	input pcCtl_t        ctl,
	input uopOperation_t operation,
	input uopOperand_t   operand
);
	expUop_t e;
	e.cmd.operation = operation;
	e.cmd.operand   = operand;
	e.inc = ctl inside {pcInc, pcIncEof, pcIncEofFu, pcIncEofZ, pcIncEofNz};
	e.fu  = ctl inside {pcEofFu, pcIncEofFu, pcUpdateFlags};
	case (ctl)
		pcEof, pcIncEof, pcEofFu, pcIncEofFu:
			e.last = 1'b1;
		pcIncEofZ:
			e.last = zeroFlag;
		pcIncEofNz:
			e.last = !zeroFlag;
		default:
			e.last = 1'b0;
	endcase
	// Steps past a taken end are never issued
	if (!flowClosed)
	begin
		expQ.push_back(e);
		flowClosed = e.last;
	end
endtask

task automatic addLoad(input uopOperand_t r);
	pushStep(pcInc, opSma, rPc);
	pushStep(pcInc, opNop, rNull);
	pushStep(pcEof, opSrm, r);
endtask

task automatic addAlu(input uopOperation_t operation, input uopOperand_t r);
	pushStep(pcOp, opSx16r, rA);
	pushStep(pcUpdateFlags, operation, r);
	pushStep(pcIncEof, opSrx16, rA);
endtask

// Relative jump where step 3 decides whether the branch is taken
task automatic addJump(input pcCtl_t offsetCtl);
	pushStep(pcInc, opSma, rPc);
	pushStep(pcOp, opNop, rNull);
	pushStep(offsetCtl, opSrm, rX8);
	pushStep(pcOp, opSx16r, rPc);
	pushStep(pcOp, opAddx16, rX8);
	pushStep(pcEof, opSpc, rX16);
endtask

task automatic addFlow(input reqKind_t kind, input logic [7:0] opc);
	flowClosed = 1'b0;
	if (kind == reqPrefix)
	begin
		pushStep(pcInc, opSma, rPc);
		pushStep(pcOp, opNop, rNull);
		pushStep(pcIncEof, opJcb, rNull);
	end
	else if (kind == reqCb)
	begin
		case (opc)
			8'h7C:
				pushStep(pcEofFu, opBit, rNull);
			8'h38:
			begin
				pushStep(pcUpdateFlags, opShr, rNull);
				pushStep(pcEof, opNop, rNull);
			end
			8'h18, 8'h19, 8'h1A, 8'h1B, 8'h1C, 8'h1D, 8'h1F:
			begin
				pushStep(pcUpdateFlags, opRrot, rNull);
				pushStep(pcEof, opNop, rNull);
			end
			default:
				pushStep(pcIncEofFu, opZ801bop, rA);
		endcase
	end
	else
	begin
		case (opc)
			8'h00: pushStep(pcIncEof, opNop, rNull);
			8'h3E: addLoad(rA);
			8'h06: addLoad(rB);
			8'h0E: addLoad(rC);
			8'h0C: pushStep(pcIncEofFu, opInc16, rC);
			8'h3D: pushStep(pcIncEofFu, opDec16, rA);
			8'h0D: pushStep(pcIncEofFu, opDec16, rC);
			8'h87: addAlu(opAddx16u, rA);
			8'h80: addAlu(opAddx16u, rB);
			8'h90: addAlu(opSubx16, rB);
			8'h91: addAlu(opSubx16, rC);
			8'h20: addJump(pcIncEofZ);
			8'h28: addJump(pcIncEofNz);
			8'h18: addJump(pcInc);
			default:
			begin
				pushStep(pcUpdateFlags, opZ801bop, rA);
				pushStep(pcIncEof, opNop, rNull);
			end
		endcase
	end
endtask

//////////////////////////////
// Compares and waits
//////////////////////////////

task automatic checkCmd(input uopCmd_t got, input uopCmd_t want, input string what);
	if (got !== want)
	begin
		$display("error at %0t ns: %s is %h, expected %h", $time, what, got, want);
		failNow("micro-op command mismatch");
	end
endtask

task automatic checkBit(input logic got, input logic want, input string what);
	if (got !== want)
	begin
		$display("error at %0t ns: %s is %b, expected %b", $time, what, got, want);
		failNow("strobe mismatch");
	end
endtask

// Returns at a falling edge with ready high
task automatic waitReady();
	int cycles;
	cycles = 0;
	@(negedge clock);
	while (ready !== 1'b1 && cycles < 20)
	begin
		@(negedge clock);
		cycles++;
	end
	if (ready !== 1'b1)
		failNow("ready never came back high");
endtask

// Waits until every expected micro-op has been seen
task automatic waitFlowEnd();
	int cycles;
	cycles = 0;
	while (expQ.size() != 0 && cycles < 40)
	begin
		@(posedge clock);
		cycles++;
	end
	if (expQ.size() != 0)
		failNow("flowEnd of the expected flow never arrived");
	#1;
endtask

/* tb/tbUcodeSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module tbUcodeSequencer import ucodePkg::*;
();

	logic       clock = 1'b0;
	logic       arstN;
	logic       opcodeValid;
	logic [7:0] opcode;
	logic       zeroFlag;
	logic       ready;
	uopCmd_t    uop;
	logic       uopValid;
	logic       pcIncrement;
	logic       flagsUpdate;
	logic       flowEnd;

	logic       inPrefix;
	integer     seed = 51807;
	logic [7:0] cbCodes[$];

	task automatic failNow(input string why);
		$display(">>> FAIL");
		$fatal(1, "%s", why);
	endtask

	`include "tbChecks.svh"

	expUop_t nextExp;

	ucodeSequencer uut
	(
		.clock       (clock),
		.arstN       (arstN),
		.opcodeValid (opcodeValid),
		.opcode      (opcode),
		.zeroFlag    (zeroFlag),
		.ready       (ready),
		.uop         (uop),
		.uopValid    (uopValid),
		.pcIncrement (pcIncrement),
		.flagsUpdate (flagsUpdate),
		.flowEnd     (flowEnd)
	);

	always #5 clock = ~clock;

	// Scoreboard on the falling edge where outputs are stable
	always @(negedge clock)
	begin
		if (arstN && uopValid)
		begin
			if (expQ.size() == 0)
				failNow("micro-op issued while none was expected");
			else
			begin
				nextExp = expQ.pop_front();
				checkCmd(uop, nextExp.cmd, "uop");
				checkBit(pcIncrement, nextExp.inc, "pcIncrement");
				checkBit(flagsUpdate, nextExp.fu, "flagsUpdate");
				checkBit(flowEnd, nextExp.last, "flowEnd");
			end
		end
		else if (arstN)
		begin
			checkBit(pcIncrement, 1'b0, "idle pcIncrement");
			checkBit(flagsUpdate, 1'b0, "idle flagsUpdate");
			checkBit(flowEnd, 1'b0, "idle flowEnd");
		end
	end

	// Offers one byte until taken and can keep the strobe up for the next one
	task automatic sendOpcode(input logic [7:0] opc, input logic holdValid);
		reqKind_t kind;
		if (inPrefix)
			kind = reqCb;
		else if (opc == opcPrefixCb)
			kind = reqPrefix;
		else
			kind = reqMain;
		inPrefix = (kind == reqPrefix);
		addFlow(kind, opc);
		opcodeValid = 1'b1;
		opcode      = opc;
		waitReady();
		@(posedge clock);
		#1;
		opcodeValid = holdValid;
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////

	task automatic testReset();
		@(negedge clock);
		checkBit(ready, 1'b1, "ready after reset");
		checkBit(uopValid, 1'b0, "uopValid after reset");
		@(posedge clock);
		#1;
	endtask

	task automatic testMainFlows();
		logic [7:0] codes[$];
		codes = '{opcNop, opcLdAn, opcLdBn, opcLdCn, opcIncC, opcDecA, opcDecC,
			opcAddA, opcAddB, opcSubB, opcSubC, 8'hD3};
		foreach (codes[i])
		begin
			sendOpcode(codes[i], 1'b0);
			waitFlowEnd();
		end
	endtask

	task automatic testJumps();
		for (int z = 0; z < 2; z++)
		begin
			zeroFlag = z[0];
			sendOpcode(opcJr, 1'b0);
			waitFlowEnd();
			sendOpcode(opcJrNz, 1'b0);
			waitFlowEnd();
			sendOpcode(opcJrZ, 1'b0);
			waitFlowEnd();
		end
		zeroFlag = 1'b0;
	endtask

	// RR order is shuffled from the fixed seed
	task automatic testCbFlows();
		int         j;
		logic [7:0] t;
		cbCodes = '{cbBit7H, cbSrlB, cbRrB, cbRrC, cbRrD, cbRrE, cbRrH, cbRrL, cbRrA, 8'h00};
		for (int i = 2; i < 8; i++)
		begin
			j = 2 + ($unsigned($random(seed)) % (9 - i));
			t = cbCodes[i];
			cbCodes[i] = cbCodes[j];
			cbCodes[j] = t;
		end
		foreach (cbCodes[i])
		begin
			sendOpcode(opcPrefixCb, 1'b0);
			waitFlowEnd();
			sendOpcode(cbCodes[i], 1'b0);
			waitFlowEnd();
		end
		// Back in the main table
		sendOpcode(opcJr, 1'b0);
		waitFlowEnd();
	endtask

	task automatic testStream();
		sendOpcode(opcLdAn, 1'b1);
		sendOpcode(opcAddB, 1'b1);
		sendOpcode(opcPrefixCb, 1'b1);
		sendOpcode(cbSrlB, 1'b1);
		sendOpcode(opcDecC, 1'b1);
		sendOpcode(opcJrZ, 1'b1);
		sendOpcode(opcNop, 1'b0);
		waitFlowEnd();
	endtask

	// Bytes held up while the sequencer is busy must not start a flow
	task automatic testIgnored();
		sendOpcode(opcJr, 1'b0);
		for (int i = 0; i < 3; i++)
		begin
			opcodeValid = 1'b1;
			opcode      = opcIncC;
			@(negedge clock);
			checkBit(ready, 1'b0, "ready while busy");
			@(posedge clock);
			#1;
		end
		opcodeValid = 1'b0;
		waitFlowEnd();
		repeat (4) @(posedge clock);
		#1;
	endtask

	initial
	begin
		arstN       = 1'b0;
		opcodeValid = 1'b0;
		opcode      = 8'h00;
		zeroFlag    = 1'b0;
		inPrefix    = 1'b0;
		flowClosed  = 1'b0;
		repeat (4) @(posedge clock);
		#1;
		arstN = 1'b1;
		testReset();
		testMainFlows();
		testJumps();
		testCbFlows();
		testStream();
		testIgnored();
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* source/ucodeSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module ucodeSequencer import ucodePkg::*;
(
	input  logic       clock,
	input  logic       arstN,
	input  logic       opcodeValid,
	input  logic [7:0] opcode,
	input  logic       zeroFlag,
	output logic       ready,
	output uopCmd_t    uop,
	output logic       uopValid,
	output logic       pcIncrement,
	output logic       flagsUpdate,
	output logic       flowEnd
);

	flowReq_t request;
	logic     start;
	uAddr_t   startAddr;
	uAddr_t   addr;
	uopWord_t word;
	logic     active;
	logic     lastWord;

	//////////////////////////////
	// Input side
	//////////////////////////////

	opcodeLatch uLatch
	(
		.clock       (clock),
		.arstN       (arstN),
		.opcodeValid (opcodeValid),
		.opcode      (opcode),
		.ready       (ready),
		.request     (request),
		.start       (start)
	);

	flowLookup uLookup
	(
		.request   (request),
		.startAddr (startAddr)
	);

	// Micro-PC and its ROM
	microSequencer uSeq
	(
		.clock     (clock),
		.arstN     (arstN),
		.start     (start),
		.startAddr (startAddr),
		.word      (word),
		.zeroFlag  (zeroFlag),
		.addr      (addr),
		.active    (active),
		.lastWord  (lastWord),
		.ready     (ready)
	);

	microcodeRom uRom
	(
		.addr (addr),
		.word (word)
	);

	//////////////////////////////
	// Output side
	//////////////////////////////

	uopDecoder uDecoder
	(
		.clock       (clock),
		.arstN       (arstN),
		.active      (active),
		.lastWord    (lastWord),
		.word        (word),
		.uop         (uop),
		.uopValid    (uopValid),
		.pcIncrement (pcIncrement),
		.flagsUpdate (flagsUpdate),
		.flowEnd     (flowEnd)
	);

endmodule

`default_nettype wire

/* source/uopDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module uopDecoder import ucodePkg::*;
(
	input  logic     clock,
	input  logic     arstN,
	input  logic     active,
	input  logic     lastWord,
	input  uopWord_t word,
	output uopCmd_t  uop,
	output logic     uopValid,
	output logic     pcIncrement,
	output logic     flagsUpdate,
	output logic     flowEnd
);

	logic incStrobe;
	logic fuStrobe;

	// Inc forms raise the strobe whether or not their condition ends the flow
	always_comb
	begin
		incStrobe = 1'b0;
		fuStrobe  = 1'b0;
		case (word.pcCtl)
			pcInc, pcIncEof, pcIncEofZ, pcIncEofNz:
				incStrobe = 1'b1;
			pcIncEofFu:
			begin
				incStrobe = 1'b1;
				fuStrobe  = 1'b1;
			end
			pcEofFu, pcUpdateFlags:
				fuStrobe = 1'b1;
			default:
				incStrobe = 1'b0;
		endcase
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			uopValid    <= 1'b0;
			pcIncrement <= 1'b0;
			flagsUpdate <= 1'b0;
			flowEnd     <= 1'b0;
		end
		else
		begin
			uopValid    <= active;
			pcIncrement <= active && incStrobe;
			flagsUpdate <= active && fuStrobe;
			flowEnd     <= lastWord;
		end
	end

	always_ff @(posedge clock)
	begin
		uop <= word.cmd;
	end

endmodule

`default_nettype wire

/* source/microSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module microSequencer import ucodePkg::*;
(
	input  logic     clock,
	input  logic     arstN,
	input  logic     start,
	input  uAddr_t   startAddr,
	input  uopWord_t word,
	input  logic     zeroFlag,
	output uAddr_t   addr,
	output logic     active,
	output logic     lastWord,
	output logic     ready
);

	typedef enum logic {
		seqIdle,
		seqRun
	} seqState_t;

	seqState_t state;
	logic      endNow;
	logic      load;

	// End of flow for the word at the micro-PC
	always_comb
	begin
		case (word.pcCtl)
			pcEof, pcIncEof, pcEofFu, pcIncEofFu:
				endNow = 1'b1;
			pcIncEofZ:
				endNow = zeroFlag;
			pcIncEofNz:
				endNow = !zeroFlag;
			default:
				endNow = 1'b0;
		endcase
	end

	assign active   = (state == seqRun);
	assign lastWord = active && endNow;
	assign load     = start && (!active || lastWord);

	// Low while a start is pending so a second byte is not taken early
	assign ready = (!active && !start) || lastWord;

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= seqIdle;
			addr  <= '0;
		end
		else if (load)
		begin
			state <= seqRun;
			addr  <= startAddr;
		end
		else if (lastWord)
		begin
			state <= seqIdle;
		end
		else if (active)
		begin
			addr <= addr + uAddr_t'(1);
		end
	end

endmodule

`default_nettype wire

/* source/microcodeRom.sv */
`timescale 1ns/1ps
`default_nettype none

module microcodeRom import ucodePkg::*;
(
	input  uAddr_t   addr,
	output uopWord_t word
);

	function automatic uopWord_t mkWord
	(
		input pcCtl_t        ctl,
		input uopOperation_t operation,
		input uopOperand_t   operand
	);
		uopWord_t w;
		w.pcCtl         = ctl;
		w.cmd.operation = operation;
		w.cmd.operand   = operand;
		return w;
	endfunction

	always_comb
	begin
		case (addr)
			// Unknown main opcode
			flowGeneric:       word = mkWord(pcUpdateFlags, opZ801bop, rA);
			flowGeneric + 1:   word = mkWord(pcIncEof, opNop, rNull);
			// Unknown CB opcode
			flowCbGeneric:     word = mkWord(pcIncEofFu, opZ801bop, rA);
			flowNop:           word = mkWord(pcIncEof, opNop, rNull);

			//////////////////////////////
			// Immediate loads
			//////////////////////////////
			flowLdA:           word = mkWord(pcInc, opSma, rPc);
			flowLdA + 1:       word = mkWord(pcInc, opNop, rNull);
			flowLdA + 2:       word = mkWord(pcEof, opSrm, rA);
			flowLdB:           word = mkWord(pcInc, opSma, rPc);
			flowLdB + 1:       word = mkWord(pcInc, opNop, rNull);
			flowLdB + 2:       word = mkWord(pcEof, opSrm, rB);
			flowLdC:           word = mkWord(pcInc, opSma, rPc);
			flowLdC + 1:       word = mkWord(pcInc, opNop, rNull);
			flowLdC + 2:       word = mkWord(pcEof, opSrm, rC);

			// Single step inc and dec
			flowIncC:          word = mkWord(pcIncEofFu, opInc16, rC);
			flowDecA:          word = mkWord(pcIncEofFu, opDec16, rA);
			flowDecC:          word = mkWord(pcIncEofFu, opDec16, rC);

			//////////////////////////////
			// ALU through x16
			//////////////////////////////
			flowAddA:          word = mkWord(pcOp, opSx16r, rA);
			flowAddA + 1:      word = mkWord(pcUpdateFlags, opAddx16u, rA);
			flowAddA + 2:      word = mkWord(pcIncEof, opSrx16, rA);
			flowAddB:          word = mkWord(pcOp, opSx16r, rA);
			flowAddB + 1:      word = mkWord(pcUpdateFlags, opAddx16u, rB);
			flowAddB + 2:      word = mkWord(pcIncEof, opSrx16, rA);
			flowSubB:          word = mkWord(pcOp, opSx16r, rA);
			flowSubB + 1:      word = mkWord(pcUpdateFlags, opSubx16, rB);
			flowSubB + 2:      word = mkWord(pcIncEof, opSrx16, rA);
			flowSubC:          word = mkWord(pcOp, opSx16r, rA);
			flowSubC + 1:      word = mkWord(pcUpdateFlags, opSubx16, rC);
			flowSubC + 2:      word = mkWord(pcIncEof, opSrx16, rA);

			//////////////////////////////
			// Relative jumps
			//////////////////////////////
			flowJrNz:          word = mkWord(pcInc, opSma, rPc);
			flowJrNz + 1:      word = mkWord(pcOp, opNop, rNull);
			flowJrNz + 2:      word = mkWord(pcIncEofZ, opSrm, rX8);
			flowJrNz + 3:      word = mkWord(pcOp, opSx16r, rPc);
			flowJrNz + 4:      word = mkWord(pcOp, opAddx16, rX8);
			flowJrNz + 5:      word = mkWord(pcEof, opSpc, rX16);
			flowJrZ:           word = mkWord(pcInc, opSma, rPc);
			flowJrZ + 1:       word = mkWord(pcOp, opNop, rNull);
			flowJrZ + 2:       word = mkWord(pcIncEofNz, opSrm, rX8);
			flowJrZ + 3:       word = mkWord(pcOp, opSx16r, rPc);
			flowJrZ + 4:       word = mkWord(pcOp, opAddx16, rX8);
			flowJrZ + 5:       word = mkWord(pcEof, opSpc, rX16);
			// Unconditional jump with offset sign extended by the datapath
			flowJr:            word = mkWord(pcInc, opSma, rPc);
			flowJr + 1:        word = mkWord(pcOp, opNop, rNull);
			flowJr + 2:        word = mkWord(pcInc, opSrm, rX8);
			flowJr + 3:        word = mkWord(pcOp, opSx16r, rPc);
			flowJr + 4:        word = mkWord(pcOp, opAddx16, rX8);
			flowJr + 5:        word = mkWord(pcEof, opSpc, rX16);

			//////////////////////////////
			// CB prefix and its flows
			//////////////////////////////
			flowMapCb:         word = mkWord(pcInc, opSma, rPc);
			flowMapCb + 1:     word = mkWord(pcOp, opNop, rNull);
			flowMapCb + 2:     word = mkWord(pcIncEof, opJcb, rNull);
			flowBit7:          word = mkWord(pcEofFu, opBit, rNull);
			flowSrl:           word = mkWord(pcUpdateFlags, opShr, rNull);
			flowSrl + 1:       word = mkWord(pcEof, opNop, rNull);
			flowRr:            word = mkWord(pcUpdateFlags, opRrot, rNull);
			flowRr + 1:        word = mkWord(pcEof, opNop, rNull);

			default:           word = mkWord(pcOp, opNop, rNull);
		endcase
	end

endmodule

`default_nettype wire

/* source/flowLookup.sv */
`timescale 1ns/1ps
`default_nettype none

module flowLookup import ucodePkg::*;
(
	input  flowReq_t request,
	output uAddr_t   startAddr
);

	uAddr_t mainAddr;
	uAddr_t cbAddr;

	//////////////////////////////
	// Main table
	//////////////////////////////

	always_comb
	begin
		case (request.opcode)
			opcNop:  mainAddr = flowNop;
			opcLdAn: mainAddr = flowLdA;
			opcLdBn: mainAddr = flowLdB;
			opcLdCn: mainAddr = flowLdC;
			opcIncC: mainAddr = flowIncC;
			opcDecA: mainAddr = flowDecA;
			opcDecC: mainAddr = flowDecC;
			opcAddA: mainAddr = flowAddA;
			opcAddB: mainAddr = flowAddB;
			opcSubB: mainAddr = flowSubB;
			opcSubC: mainAddr = flowSubC;
			opcJrNz: mainAddr = flowJrNz;
			opcJrZ:  mainAddr = flowJrZ;
			opcJr:   mainAddr = flowJr;
			default: mainAddr = flowGeneric;
		endcase
	end

	//////////////////////////////
	// CB table
	//////////////////////////////

	always_comb
	begin
		case (request.opcode)
			cbBit7H: cbAddr = flowBit7;
			cbSrlB:  cbAddr = flowSrl;
			// All RR register forms share one flow
			cbRrB, cbRrC, cbRrD, cbRrE, cbRrH, cbRrL, cbRrA:
				cbAddr = flowRr;
			default: cbAddr = flowCbGeneric;
		endcase
	end

	always_comb
	begin
		case (request.kind)
			reqPrefix: startAddr = flowMapCb;
			reqCb:     startAddr = cbAddr;
			default:   startAddr = mainAddr;
		endcase
	end

endmodule

`default_nettype wire

/* source/opcodeLatch.sv */
`timescale 1ns/1ps
`default_nettype none

module opcodeLatch import ucodePkg::*;
(
	input  logic       clock,
	input  logic       arstN,
	input  logic       opcodeValid,
	input  logic [7:0] opcode,
	input  logic       ready,
	output flowReq_t   request,
	output logic       start
);

	logic     accept;
	logic     prefixState;
	reqKind_t kind;

	assign accept = opcodeValid && ready;

	// Byte after a prefix always goes to the CB table
	always_comb
	begin
		if (prefixState)
			kind = reqCb;
		else if (opcode == opcPrefixCb)
			kind = reqPrefix;
		else
			kind = reqMain;
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			prefixState <= 1'b0;
			start       <= 1'b0;
		end
		else
		begin
			start <= accept;
			if (accept)
				prefixState <= (kind == reqPrefix);
		end
	end

	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			request.kind   <= kind;
			request.opcode <= opcode;
		end
	end

endmodule

`default_nettype wire

/* source/ucodePkg.sv */
`default_nettype none

package ucodePkg;

	//////////////////////////////
	// Micro-op word fields
	//////////////////////////////

	localparam int romDepth = 64;

	typedef logic [$clog2(romDepth)-1:0] uAddr_t;

	// PC and sequencing control
	typedef enum logic [3:0] {
		pcOp,
		pcInc,
		pcEof,
		pcIncEof,
		pcEofFu,
		pcIncEofFu,
		pcUpdateFlags,
		pcIncEofZ,
		pcIncEofNz
	} pcCtl_t;

	typedef enum logic [4:0] {
		opNop, opSma, opSrm, opSx16r,
		opSrx16, opAddx16, opAddx16u, opSubx16,
		opSpc, opInc16, opDec16, opBit,
		opShr, opRrot, opJcb, opZ801bop
	} uopOperation_t;

	typedef enum logic [3:0] {
		rA, rB, rC, rH,
		rPc, rX8, rX16, rNull
	} uopOperand_t;

	// Command as seen by the datapath
	typedef struct packed {
		uopOperation_t operation;
		uopOperand_t   operand;
	} uopCmd_t;

	// One ROM entry
	typedef struct packed {
		pcCtl_t  pcCtl;
		uopCmd_t cmd;
	} uopWord_t;

	typedef enum logic [1:0] {
		reqMain,
		reqPrefix,
		reqCb
	} reqKind_t;

	typedef struct packed {
		reqKind_t   kind;
		logic [7:0] opcode;
	} flowReq_t;

	//////////////////////////////
	// Flow start addresses
	//////////////////////////////

	localparam uAddr_t flowGeneric   = 6'd0;
	localparam uAddr_t flowCbGeneric = 6'd2;
	localparam uAddr_t flowNop       = 6'd3;
	localparam uAddr_t flowLdA       = 6'd4;
	localparam uAddr_t flowLdB       = 6'd7;
	localparam uAddr_t flowLdC       = 6'd10;
	localparam uAddr_t flowIncC      = 6'd13;
	localparam uAddr_t flowDecA      = 6'd14;
	localparam uAddr_t flowDecC      = 6'd15;
	localparam uAddr_t flowAddA      = 6'd16;
	localparam uAddr_t flowAddB      = 6'd19;
	localparam uAddr_t flowSubB      = 6'd22;
	localparam uAddr_t flowSubC      = 6'd25;
	localparam uAddr_t flowJrNz      = 6'd28;
	localparam uAddr_t flowJrZ       = 6'd34;
	localparam uAddr_t flowJr        = 6'd40;
	localparam uAddr_t flowMapCb     = 6'd46;
	localparam uAddr_t flowBit7      = 6'd49;
	localparam uAddr_t flowSrl       = 6'd50;
	localparam uAddr_t flowRr        = 6'd52;

	//////////////////////////////
	// Opcodes
	//////////////////////////////

	localparam logic [7:0] opcNop      = 8'h00;
	localparam logic [7:0] opcLdAn     = 8'h3E;
	localparam logic [7:0] opcLdBn     = 8'h06;
	localparam logic [7:0] opcLdCn     = 8'h0E;
	localparam logic [7:0] opcIncC     = 8'h0C;
	localparam logic [7:0] opcDecA     = 8'h3D;
	localparam logic [7:0] opcDecC     = 8'h0D;
	localparam logic [7:0] opcAddA     = 8'h87;
	localparam logic [7:0] opcAddB     = 8'h80;
	localparam logic [7:0] opcSubB     = 8'h90;
	localparam logic [7:0] opcSubC     = 8'h91;
	localparam logic [7:0] opcJrNz     = 8'h20;
	localparam logic [7:0] opcJrZ      = 8'h28;
	localparam logic [7:0] opcJr       = 8'h18;
	localparam logic [7:0] opcPrefixCb = 8'hCB;

	// Second byte after the CB prefix
	localparam logic [7:0] cbBit7H = 8'h7C;
	localparam logic [7:0] cbSrlB  = 8'h38;
	localparam logic [7:0] cbRrB   = 8'h18;
	localparam logic [7:0] cbRrC   = 8'h19;
	localparam logic [7:0] cbRrD   = 8'h1A;
	localparam logic [7:0] cbRrE   = 8'h1B;
	localparam logic [7:0] cbRrH   = 8'h1C;
	localparam logic [7:0] cbRrL   = 8'h1D;
	localparam logic [7:0] cbRrA   = 8'h1F;

endpackage

`default_nettype wire
